// File: dv/sdram_model.sv
module sdram_model
    import chart_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,

    // Write channel.
    input  logic        wr_req,
    input  sdram_addr_t wr_addr,
    input  pixel_t      wr_data,
    output logic        wr_done,

    // Read channel.
    input  logic        rd_req,
    input  sdram_addr_t rd_addr,
    output sample_t     rd_data,
    output logic        rd_done,

    output int          fault_count
);
    timeunit 1ns;
    timeprecision 100ps;

    localparam int WORDS = 2048; // Covers plot and ring.

    logic [15:0] mem [WORDS];

    logic        wr_busy;
    logic        rd_busy;
    logic [1:0]  wr_wait;  // Cycles left before done.
    logic [1:0]  rd_wait;
    sdram_addr_t wr_addr_q;
    pixel_t      wr_data_q;
    sdram_addr_t rd_addr_q;

    // Fill so that cleared words stand out.
    initial begin
        for (int i = 0; i < WORDS; i++) begin
            mem[11'(i)] = 16'(i * 40503) ^ 16'h5A5A;
        end
    end

    //////////////////////////////////////////////////
    // One transfer served at a time.
    //////////////////////////////////////////////////

    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_busy     <= 1'b0;
            rd_busy     <= 1'b0;
            wr_done     <= 1'b0;
            rd_done     <= 1'b0;
            rd_data     <= '0;
            wr_wait     <= '0;
            rd_wait     <= '0;
            fault_count <= 0;
        end else begin
            wr_done <= 1'b0;
            rd_done <= 1'b0;

            if (wr_busy) begin
                if (!wr_req || wr_addr != wr_addr_q || wr_data != wr_data_q) begin
                    $display("sdram: write request changed before done at %0t", $time);
                    fault_count <= fault_count + 1;
                end
                if (wr_wait == 2'd0) begin
                    mem[wr_addr_q[10:0]] <= wr_data_q;
                    wr_done <= 1'b1;
                    wr_busy <= 1'b0;
                end else begin
                    wr_wait <= wr_wait - 2'd1;
                end
            end else if (wr_req && !wr_done) begin
                wr_busy   <= 1'b1;
                wr_wait   <= 2'($urandom_range(0, 3)); // Done after 1 to 4 cycles.
                wr_addr_q <= wr_addr;
                wr_data_q <= wr_data;
                if (rd_req || rd_busy || wr_addr[23:11] != '0) begin
                    $display("sdram: bad write start at %0t, addr 0x%0h", $time, wr_addr);
                    fault_count <= fault_count + 1;
                end
            end

            if (rd_busy) begin
                if (!rd_req || rd_addr != rd_addr_q) begin
                    $display("sdram: read request changed before done at %0t", $time);
                    fault_count <= fault_count + 1;
                end
                if (rd_wait == 2'd0) begin
                    rd_data <= mem[rd_addr_q[10:0]];
                    rd_done <= 1'b1;
                    rd_busy <= 1'b0;
                end else begin
                    rd_wait <= rd_wait - 2'd1;
                end
            end else if (rd_req && !rd_done) begin
                rd_busy   <= 1'b1;
                rd_wait   <= 2'($urandom_range(0, 3));
                rd_addr_q <= rd_addr;
                if (wr_req || wr_busy || rd_addr[23:11] != '0) begin
                    $display("sdram: bad read start at %0t, addr 0x%0h", $time, rd_addr);
                    fault_count <= fault_count + 1;
                end
            end
        end
    end

endmodule

// File: dv/tb_chart.sv
`include "chart_settings.svh"

module tb_chart
    import chart_pkg::*;
();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int COLS        = `CHART_COLS;
    localparam int ROWS        = `CHART_ROWS;
    localparam int FRAME_BOUND = COLS * (ROWS + 1) * 7; // Worst case frame.
    localparam int CYCLE_LIMIT = 40 * FRAME_BOUND;

    logic        clk;
    logic        rst_n;
    logic        cfg_wr;
    logic [2:0]  cfg_addr;
    logic [15:0] cfg_data;
    logic        data_update;
    sample_t     pulse_count;
    logic        wr_req;
    sdram_addr_t wr_addr;
    pixel_t      wr_data;
    logic        wr_done;
    logic        rd_req;
    sdram_addr_t rd_addr;
    sample_t     rd_data;
    logic        rd_done;
    logic        busy;
    logic        frame_done;
    int          fault_count;

    // Reference model state.
    chart_cfg_t  cfg_ref;
    sample_t     ring_ref [COLS];
    pixel_t      pix_ref [COLS][ROWS];
    int          head_ref;

    int          cycles;
    int          mismatches;
    int          failures;

    tb_clock_gen u_clk (
        .clk   (clk),
        .rst_n (rst_n)
    );

    sdram_model u_mem (
        .clk         (clk),
        .rst_n       (rst_n),
        .wr_req      (wr_req),
        .wr_addr     (wr_addr),
        .wr_data     (wr_data),
        .wr_done     (wr_done),
        .rd_req      (rd_req),
        .rd_addr     (rd_addr),
        .rd_data     (rd_data),
        .rd_done     (rd_done),
        .fault_count (fault_count)
    );

    chart_top uut (
        .clk         (clk),
        .rst_n       (rst_n),
        .cfg_wr      (cfg_wr),
        .cfg_addr    (cfg_addr),
        .cfg_data    (cfg_data),
        .data_update (data_update),
        .pulse_count (pulse_count),
        .wr_req      (wr_req),
        .wr_addr     (wr_addr),
        .wr_data     (wr_data),
        .wr_done     (wr_done),
        .rd_req      (rd_req),
        .rd_addr     (rd_addr),
        .rd_data     (rd_data),
        .rd_done     (rd_done),
        .busy        (busy),
        .frame_done  (frame_done)
    );

    //////////////////////////////////////////////////
    // Host drivers.
    //////////////////////////////////////////////////

    task automatic reg_write(input logic [2:0] addr, input logic [15:0] data);
        @(negedge clk);
        cfg_wr   = 1'b1;
        cfg_addr = addr;
        cfg_data = data;
        @(negedge clk);
        cfg_wr = 1'b0;
        case (addr)
            3'd0: cfg_ref.enable           = data[0];
            3'd1: cfg_ref.scale_shift      = data[3:0];
            3'd2: cfg_ref.bar_color        = data;
            3'd3: cfg_ref.clear_color      = data;
            3'd4: cfg_ref.background_color = data;
            default: ;
        endcase
    endtask

    task automatic push_sample(input sample_t value);
        @(negedge clk);
        data_update = 1'b1;
        pulse_count = value;
        @(negedge clk);
        data_update = 1'b0; // One-cycle strobe.
    endtask

    task automatic wait_frame(input string what);
        int n;
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while (!frame_done && n < 2 * FRAME_BOUND);
        if (!frame_done) begin
            $display("ERROR: no frame_done within %0d cycles in %s", n, what);
            failures++;
        end else if (busy !== 1'b0) begin
            $display("MISMATCH busy at frame_done: expected 0x0, got 0x%h", busy);
            mismatches++;
        end
    endtask

    task automatic wait_busy();
        int n;
        n = 0;
        while (!busy && n < FRAME_BOUND) begin
            @(negedge clk);
            n++;
        end
        if (!busy) begin
            $display("ERROR: busy never rose after a sample");
            failures++;
        end
    endtask

    //////////////////////////////////////////////////
    // Reference model.
    //////////////////////////////////////////////////

    // Store at head, then move head on.
    function automatic void store_ref(input sample_t value);
        ring_ref[col_idx_t'(head_ref)] = value;
        head_ref = (head_ref + 1) % COLS;
    endfunction

    function automatic void fill_background();
        for (int c = 0; c < COLS; c++) begin
            for (int h = 0; h < ROWS; h++) begin
                pix_ref[col_idx_t'(c)][row_idx_t'(h)] = cfg_ref.background_color;
            end
        end
    endfunction

    // Oldest slot left, scaled and clipped bar.
    function automatic void predict_bars();
        int slot;
        int v;
        for (int c = 0; c < COLS; c++) begin
            slot = (head_ref + c) % COLS;
            v = int'(ring_ref[col_idx_t'(slot)] >> cfg_ref.scale_shift);
            if (v > ROWS - 1) begin
                v = ROWS - 1;
            end
            for (int h = 0; h < ROWS; h++) begin
                pix_ref[col_idx_t'(c)][row_idx_t'(h)] =
                    (h > v) ? cfg_ref.clear_color : cfg_ref.bar_color;
            end
        end
    endfunction

    //////////////////////////////////////////////////
    // Memory checks.
    //////////////////////////////////////////////////

    task automatic check_word(input string name, input int addr, input logic [15:0] exp);
        logic [15:0] got;
        got = u_mem.mem[11'(addr)];
        if (got !== exp) begin
            $display("MISMATCH %s[0x%0h]: expected 0x%h, got 0x%h", name, addr, exp, got);
            mismatches++;
        end
    endtask

    task automatic check_ring();
        for (int s = 0; s < COLS; s++) begin
            check_word("ring", `CHART_RING_BASE + s, ring_ref[col_idx_t'(s)]);
        end
    endtask

    task automatic check_plot();
        for (int c = 0; c < COLS; c++) begin
            for (int h = 0; h < ROWS; h++) begin
                check_word("pixel", `CHART_PLOT_BASE + c * `CHART_STRIDE + h,
                           pix_ref[col_idx_t'(c)][row_idx_t'(h)]);
            end
        end
    endtask

    //////////////////////////////////////////////////
    // Directed tests.
    //////////////////////////////////////////////////

    task automatic test_init();
        reg_write(3'd4, 16'h18E3); // Background distinct from zero.
        reg_write(3'd0, 16'h0001);
        wait_frame("test_init");
        fill_background();
        check_ring(); // Ring cleared to zero.
        check_plot();
    endtask

    task automatic test_single_sample();
        reg_write(3'd1, 16'h0000);
        push_sample(16'd5);
        store_ref(16'd5);
        wait_frame("test_single_sample");
        predict_bars();
        check_ring();
        check_plot();
    endtask

    task automatic test_scale_and_clip();
        reg_write(3'd1, 16'h0002);
        push_sample(16'd9);        // Height 2.
        store_ref(16'd9);
        wait_frame("test_scale_and_clip first");
        push_sample(16'd1000);     // Clipped to the top row.
        store_ref(16'd1000);
        wait_frame("test_scale_and_clip second");
        predict_bars();
        check_ring();
        check_plot();
    endtask

    task automatic test_scroll_wrap();
        sample_t value;
        reg_write(3'd1, 16'h0001);
        for (int i = 0; i < COLS + 3; i++) begin
            value = sample_t'($urandom_range(0, 40));
            push_sample(value);
            store_ref(value);
            wait_frame("test_scroll_wrap");
            predict_bars();
            check_plot();
        end
        check_ring();
    endtask

    task automatic test_colors_and_pending();
        sample_t first;
        sample_t second;
        first  = sample_t'($urandom_range(0, 40));
        second = sample_t'($urandom_range(0, 40));
        reg_write(3'd2, 16'h07E0);
        reg_write(3'd3, 16'h001F);
        push_sample(first);
        wait_busy();
        push_sample(second); // Held while the first frame runs.
        store_ref(first);
        store_ref(second);
        wait_frame("test_colors_and_pending first");
        wait_frame("test_colors_and_pending second");
        predict_bars();
        check_ring();
        check_plot();
    endtask

    task automatic test_disable();
        logic seen;
        seen = 1'b0;
        reg_write(3'd0, 16'h0000);
        push_sample(16'd77);
        for (int n = 0; n < FRAME_BOUND; n++) begin
            @(negedge clk);
            if (frame_done || busy) begin
                seen = 1'b1;
            end
        end
        if (seen) begin
            $display("ERROR: a frame ran while enable was clear");
            failures++;
        end
        store_ref(16'd77);
        reg_write(3'd0, 16'h0001); // Held sample now drawn.
        wait_frame("test_disable");
        predict_bars();
        check_ring();
        check_plot();
    endtask

    //////////////////////////////////////////////////
    // Sequence and watchdog.
    //////////////////////////////////////////////////

    initial begin
        void'($urandom(50));
        cfg_wr      = 1'b0;
        cfg_addr    = '0;
        cfg_data    = '0;
        data_update = 1'b0;
        pulse_count = '0;
        head_ref    = 0;
        mismatches  = 0;
        failures    = 0;
        cfg_ref     = {1'b0, 4'h0, 16'hF81F, 16'h8410, 16'h0000}; // Reset values.
        for (int s = 0; s < COLS; s++) begin
            ring_ref[col_idx_t'(s)] = '0;
        end

        wait (rst_n === 1'b1);
        @(negedge clk);

        test_init();
        test_single_sample();
        test_scale_and_clip();
        test_scroll_wrap();
        test_colors_and_pending();
        test_disable();

        if (fault_count != 0) begin
            $display("ERROR: memory model saw %0d handshake faults", fault_count);
            failures += fault_count;
        end
        $display("Summary: %0d mismatches, %0d other errors", mismatches, failures);
        if (mismatches == 0 && failures == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

    initial begin
        cycles = 0;
        while (cycles < CYCLE_LIMIT) begin
            @(posedge clk);
            cycles++;
        end
        $display("ERROR: timeout after %0d cycles", cycles);
        $display("Summary: %0d mismatches, %0d other errors", mismatches, failures + 1);
        $display("*** FAILED ***");
        $finish;
    end

endmodule

// File: dv/tb_clock_gen.sv
module tb_clock_gen (
    output logic clk,
    output logic rst_n
);
    timeunit 1ns;
    timeprecision 100ps;

    localparam int RESET_CYCLES = 10;

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk; // 4 ns period.
    end

    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1; // Released on the falling edge.
    end

endmodule

// File: list.f
+incdir+logic
logic/chart_pkg.sv
logic/chart_regs.sv
logic/chart_sample_ring.sv
logic/chart_draw_engine.sv
logic/chart_top.sv
dv/tb_clock_gen.sv
dv/sdram_model.sv
dv/tb_chart.sv

// File: logic/chart_draw_engine.sv
`include "chart_settings.svh"

module chart_draw_engine
    import chart_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,

    input  chart_cfg_t  cfg,

    // Sample ring.
    input  logic        pending,
    input  sample_t     sample,
    input  sdram_addr_t store_addr,
    input  sdram_addr_t read_addr,
    output logic        take,
    output logic        advance,
    output col_idx_t    col_sel,

    // SDRAM write channel.
    output logic        wr_req,
    output sdram_addr_t wr_addr,
    output pixel_t      wr_data,
    input  logic        wr_done,

    // SDRAM read channel.
    output logic        rd_req,
    output sdram_addr_t rd_addr,
    input  sample_t     rd_data,
    input  logic        rd_done,

    output logic        busy,
    output logic        frame_done
);

    draw_state_t state;

    col_idx_t    col_cnt;    // Column, or ring slot during init.
    row_idx_t    row_cnt;    // Height, counts down.

    sample_t     store_data; // Taken count for this frame.
    row_idx_t    bar_h;      // Clipped bar height of the column.
    pixel_t      bar_q;
    pixel_t      clear_q;

    sdram_addr_t pix_addr;
    sdram_addr_t next_wr_addr;
    pixel_t      next_wr_data;
    sample_t     scaled;
    row_idx_t    clip_h;

    logic        wr_start;
    logic        wr_ack;
    logic        rd_start;
    logic        rd_ack;
    logic        last_row;
    logic        last_col;

    //////////////////////////////////////////////////
    // Handshake and datapath decode.
    //////////////////////////////////////////////////

    assign wr_ack   = wr_req && wr_done;
    assign rd_ack   = rd_req && rd_done;
    assign rd_start = !rd_req && (state == READ);
    assign last_row = (row_cnt == '0); // Height 0 is painted last.
    assign last_col = (col_cnt == col_idx_t'(`CHART_COLS - 1));

    // Init waits for enable; once started it runs to the end.
    always_comb begin
        wr_start = 1'b0;
        if (!wr_req) begin
            case (state)
                INIT_RING: wr_start = cfg.enable || busy;
                INIT_PLOT, STORE, PAINT: wr_start = 1'b1;
                default: wr_start = 1'b0;
            endcase
        end
    end

    assign take    = (state == IDLE) && pending && cfg.enable;
    assign advance = (state == STORE) && wr_ack; // Head moves after the store.
    assign col_sel = col_cnt;

    assign pix_addr = sdram_addr_t'(`CHART_PLOT_BASE)
                    + sdram_addr_t'(col_cnt) * sdram_addr_t'(`CHART_STRIDE)
                    + sdram_addr_t'(row_cnt);

    // Scale, then clip to the plot height.
    always_comb begin
        scaled = rd_data >> cfg.scale_shift;
        if (scaled > sample_t'(`CHART_ROWS - 1)) begin
            clip_h = row_idx_t'(`CHART_ROWS - 1);
        end else begin
            clip_h = row_idx_t'(scaled);
        end
    end

    always_comb begin
        case (state)
            INIT_RING: begin
                next_wr_addr = read_addr; // Head is 0, so slot = col_cnt.
                next_wr_data = '0;
            end
            INIT_PLOT: begin
                next_wr_addr = pix_addr;
                next_wr_data = cfg.background_color;
            end
            STORE: begin
                next_wr_addr = store_addr;
                next_wr_data = store_data;
            end
            default: begin
                next_wr_addr = pix_addr;
                next_wr_data = (row_cnt > bar_h) ? clear_q : bar_q;
            end
        endcase
    end

    // Request payload, held stable until done.
    always_ff @(posedge clk) begin
        if (wr_start) begin
            wr_addr <= next_wr_addr;
            wr_data <= next_wr_data;
        end
        if (rd_start) begin
            rd_addr <= read_addr;
        end
        if (take) begin
            store_data <= sample;
        end
        if (rd_ack) begin
            bar_h   <= clip_h;
            bar_q   <= cfg.bar_color;   // Colors sampled per column.
            clear_q <= cfg.clear_color;
        end
    end

    //////////////////////////////////////////////////
    // FSM.
    //////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state      <= INIT_RING;
            col_cnt    <= '0;
            row_cnt    <= row_idx_t'(`CHART_ROWS - 1);
            wr_req     <= 1'b0;
            rd_req     <= 1'b0;
            busy       <= 1'b0;
            frame_done <= 1'b0;
        end else begin
            frame_done <= 1'b0;

            if (wr_start) begin
                wr_req <= 1'b1;
                busy   <= 1'b1; // First request opens the frame.
            end else if (wr_ack) begin
                wr_req <= 1'b0;
            end

            if (rd_start) begin
                rd_req <= 1'b1;
            end else if (rd_ack) begin
                rd_req <= 1'b0;
            end

            case (state)
                INIT_RING: begin
                    if (wr_ack) begin
                        if (last_col) begin
                            col_cnt <= '0;
                            row_cnt <= row_idx_t'(`CHART_ROWS - 1);
                            state   <= INIT_PLOT;
                        end else begin
                            col_cnt <= col_cnt + 1'b1;
                        end
                    end
                end
                INIT_PLOT: begin
                    if (wr_ack) begin
                        if (!last_row) begin
                            row_cnt <= row_cnt - 1'b1;
                        end else if (last_col) begin
                            frame_done <= 1'b1; // Background done.
                            busy       <= 1'b0;
                            state      <= IDLE;
                        end else begin
                            col_cnt <= col_cnt + 1'b1;
                            row_cnt <= row_idx_t'(`CHART_ROWS - 1);
                        end
                    end
                end
                IDLE: begin
                    if (take) begin
                        state <= STORE;
                    end
                end
                STORE: begin
                    if (wr_ack) begin
                        col_cnt <= '0; // Oldest slot first.
                        state   <= READ;
                    end
                end
                READ: begin
                    if (rd_ack) begin
                        row_cnt <= row_idx_t'(`CHART_ROWS - 1); // Top down.
                        state   <= PAINT;
                    end
                end
                PAINT: begin
                    if (wr_ack) begin
                        if (!last_row) begin
                            row_cnt <= row_cnt - 1'b1;
                        end else if (last_col) begin
                            frame_done <= 1'b1;
                            busy       <= 1'b0;
                            state      <= IDLE;
                        end else begin
                            state <= NEXT_COL;
                        end
                    end
                end
                NEXT_COL: begin
                    col_cnt <= col_cnt + 1'b1;
                    state   <= READ;
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

endmodule

// File: logic/chart_pkg.sv
`include "chart_settings.svh"

package chart_pkg;

    //////////////////////////////////////////////////
    // Vector types.
    //////////////////////////////////////////////////

    typedef logic [23:0] sdram_addr_t; // Bank + row + column word address.
    typedef logic [15:0] pixel_t;      // RGB565.
    typedef logic [15:0] sample_t;     // Raw pulse count.

    typedef logic [$clog2(`CHART_COLS)-1:0] col_idx_t; // Column or ring slot.
    typedef logic [$clog2(`CHART_ROWS)-1:0] row_idx_t; // Height in plot.
    typedef logic [3:0] shift_t;                       // Right shift of a count.

    // Renderer settings from the register block.
    typedef struct packed {
        logic   enable;
        shift_t scale_shift;
        pixel_t bar_color;
        pixel_t clear_color;
        pixel_t background_color;
    } chart_cfg_t;

    // Draw engine states.
    typedef enum logic [2:0] {
        INIT_RING,
        INIT_PLOT,
        IDLE,
        STORE,
        READ,
        PAINT,
        NEXT_COL
    } draw_state_t;

endpackage

// File: logic/chart_regs.sv
module chart_regs
    import chart_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,

    // Host write port.
    input  logic       cfg_wr,
    input  logic [2:0] cfg_addr,
    input  logic [15:0] cfg_data,

    output chart_cfg_t cfg
);

    // Register map.
    localparam logic [2:0] ADDR_ENABLE = 3'd0;
    localparam logic [2:0] ADDR_SHIFT  = 3'd1;
    localparam logic [2:0] ADDR_BAR    = 3'd2;
    localparam logic [2:0] ADDR_CLEAR  = 3'd3;
    localparam logic [2:0] ADDR_BACK   = 3'd4;

    // Power-on colors.
    localparam pixel_t BAR_INIT   = 16'hF81F; // Pink.
    localparam pixel_t CLEAR_INIT = 16'h8410; // Gray.
    localparam pixel_t BACK_INIT  = 16'h0000; // Black.

    //////////////////////////////////////////////////
    // Write decode.
    //////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cfg.enable           <= 1'b0;
            cfg.scale_shift      <= '0;
            cfg.bar_color        <= BAR_INIT;
            cfg.clear_color      <= CLEAR_INIT;
            cfg.background_color <= BACK_INIT;
        end else if (cfg_wr) begin
            case (cfg_addr)
                ADDR_ENABLE: cfg.enable      <= cfg_data[0];   // Bit 0 only.
                ADDR_SHIFT:  cfg.scale_shift <= cfg_data[3:0]; // Low nibble.
                ADDR_BAR:    cfg.bar_color   <= cfg_data;
                ADDR_CLEAR:  cfg.clear_color <= cfg_data;
                ADDR_BACK:   cfg.background_color <= cfg_data;
                default: begin
                    // Unmapped address, write dropped.
                end
            endcase
        end
    end

endmodule

// File: logic/chart_sample_ring.sv
`include "chart_settings.svh"

module chart_sample_ring
    import chart_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,

    // New pulse count from the counter.
    input  logic        data_update,
    input  sample_t     pulse_count,

    // Engine side.
    input  logic        take,
    input  logic        advance,
    input  col_idx_t    col_sel,

    output logic        pending,
    output sample_t     sample,
    output sdram_addr_t store_addr,
    output sdram_addr_t read_addr
);

    localparam int SLOT_W = $bits(col_idx_t);

    col_idx_t          head;     // Slot of the next store.
    logic [SLOT_W:0]   slot_sum; // One extra bit for the wrap.
    col_idx_t          read_slot;

    //////////////////////////////////////////////////
    // One-deep sample latch.
    //////////////////////////////////////////////////

    // Later strobe overwrites an unserved count.
    always_ff @(posedge clk) begin
        if (data_update) begin
            sample <= pulse_count;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pending <= 1'b0;
        end else if (data_update) begin
            pending <= 1'b1; // New count wins over a take.
        end else if (take) begin
            pending <= 1'b0;
        end
    end

    //////////////////////////////////////////////////
    // Head pointer and addresses.
    //////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            head <= '0;
        end else if (advance) begin
            if (head == col_idx_t'(`CHART_COLS - 1)) begin
                head <= '0;
            end else begin
                head <= head + 1'b1;
            end
        end
    end

    // Slot (head + col_sel) mod COLS.
    always_comb begin
        slot_sum = {1'b0, head} + {1'b0, col_sel};
        if (slot_sum >= (SLOT_W + 1)'(`CHART_COLS)) begin
            read_slot = col_idx_t'(slot_sum - (SLOT_W + 1)'(`CHART_COLS));
        end else begin
            read_slot = col_idx_t'(slot_sum);
        end
    end

    assign read_addr  = sdram_addr_t'(`CHART_RING_BASE) + sdram_addr_t'(read_slot);
    assign store_addr = sdram_addr_t'(`CHART_RING_BASE) + sdram_addr_t'(head);

endmodule

// File: logic/chart_settings.svh
`ifndef CHART_SETTINGS_SVH
`define CHART_SETTINGS_SVH

//////////////////////////////////////////////////
// Plot geometry.
//////////////////////////////////////////////////

// Plot columns, one per ring slot.
`define CHART_COLS 16

// Plot height in pixels.
`define CHART_ROWS 16

//////////////////////////////////////////////////
// SDRAM word map.
//////////////////////////////////////////////////

// Frame buffer words per column line.
`define CHART_STRIDE 32

// Pixel at column 0, height 0.
`define CHART_PLOT_BASE 64

// Ring slot 0 of the sample history.
`define CHART_RING_BASE 1024

`endif

// File: logic/chart_top.sv
module chart_top
    import chart_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,

    // Host config port.
    input  logic        cfg_wr,
    input  logic [2:0]  cfg_addr,
    input  logic [15:0] cfg_data,

    // Pulse counter.
    input  logic        data_update,
    input  sample_t     pulse_count,

    // SDRAM write channel.
    output logic        wr_req,
    output sdram_addr_t wr_addr,
    output pixel_t      wr_data,
    input  logic        wr_done,

    // SDRAM read channel.
    output logic        rd_req,
    output sdram_addr_t rd_addr,
    input  sample_t     rd_data,
    input  logic        rd_done,

    output logic        busy,
    output logic        frame_done
);

    chart_cfg_t  cfg;
    logic        pending;
    sample_t     sample;
    sdram_addr_t store_addr;
    sdram_addr_t read_addr;
    logic        take;
    logic        advance;
    col_idx_t    col_sel;

    chart_regs u_regs (
        .clk      (clk),
        .rst_n    (rst_n),
        .cfg_wr   (cfg_wr),
        .cfg_addr (cfg_addr),
        .cfg_data (cfg_data),
        .cfg      (cfg)
    );

    chart_sample_ring u_ring (
        .clk         (clk),
        .rst_n       (rst_n),
        .data_update (data_update),
        .pulse_count (pulse_count),
        .take        (take),
        .advance     (advance),
        .col_sel     (col_sel),
        .pending     (pending),
        .sample      (sample),
        .store_addr  (store_addr),
        .read_addr   (read_addr)
    );

    chart_draw_engine u_engine (
        .clk        (clk),
        .rst_n      (rst_n),
        .cfg        (cfg),
        .pending    (pending),
        .sample     (sample),
        .store_addr (store_addr),
        .read_addr  (read_addr),
        .take       (take),
        .advance    (advance),
        .col_sel    (col_sel),
        .wr_req     (wr_req),
        .wr_addr    (wr_addr),
        .wr_data    (wr_data),
        .wr_done    (wr_done),
        .rd_req     (rd_req),
        .rd_addr    (rd_addr),
        .rd_data    (rd_data),
        .rd_done    (rd_done),
        .busy       (busy),
        .frame_done (frame_done)
    );

endmodule

// File: run.sh
#!/usr/bin/env bash
# Compile and run the chart renderer testbench with Verilator.

set -u

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing -f list.f --top-module tb_chart --Mdir "$BUILD_DIR"
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$BUILD_DIR/Vtb_chart" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

# The log decides the result.
if grep -qF '*** FAILED ***' "$LOG"; then
    exit 1
fi
if ! grep -qF '*** PASSED ***' "$LOG"; then
    echo "Simulation log holds no result"
    exit 1
fi
exit 0
